//--- all.f
+incdir+include
logic/fp_format_pkg.sv
logic/slice_pkg.sv
logic/slice_decode.sv
logic/slice_lane.sv
logic/slice_pipe.sv
logic/slice_result.sv
logic/fp_slice.sv
test/tb_fp_slice.sv

//--- run.sh
#!/usr/bin/env bash
# Build the fp_slice testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module tb_fp_slice -f all.f -o sim_tb_fp_slice

status=0
output=$(./obj_dir/sim_tb_fp_slice 2>&1) || status=$?
echo "$output"

if [ "$status" -eq 0 ] && grep -qx "Regression passed" <<< "$output"; then
  exit 0
fi
exit 1

//--- include/tb_vectors.svh
/*
 * Stimulus table for the fp_slice testbench
 * Each row gives op, format, vector flag, both operands, expected
 * 32-bit result and expected NV flag
 */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

typedef struct packed {
  slice_op_e   op;
  fp_fmt_e     fmt;
  logic        vectorial;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] result;
  logic        nv;
} vector_t;

localparam int unsigned NUM_VECTORS = 30;

localparam vector_t VECTORS [NUM_VECTORS] = '{
  // FP32 sign injection where a signaling NaN in b raises nothing
  '{SGNJ,  FP32, 1'b0, 32'h3f800000, 32'hc0000000, 32'hbf800000, 1'b0},
  '{SGNJN, FP32, 1'b0, 32'hbf800000, 32'hc0000000, 32'h3f800000, 1'b0},
  '{SGNJX, FP32, 1'b0, 32'hbf800000, 32'hc0000000, 32'h3f800000, 1'b0},
  '{SGNJ,  FP32, 1'b0, 32'h40490fdb, 32'h7f800001, 32'h40490fdb, 1'b0},
  // FP32 min/max over numbers, signed zeros and NaNs
  '{MIN,   FP32, 1'b0, 32'h3f800000, 32'hc0000000, 32'hc0000000, 1'b0},
  '{MAX,   FP32, 1'b0, 32'h3f800000, 32'hc0000000, 32'h3f800000, 1'b0},
  '{MIN,   FP32, 1'b0, 32'h00000000, 32'h80000000, 32'h80000000, 1'b0},
  '{MAX,   FP32, 1'b0, 32'h00000000, 32'h80000000, 32'h00000000, 1'b0},
  '{MIN,   FP32, 1'b0, 32'h7fc00000, 32'h3f800000, 32'h3f800000, 1'b0},
  '{MAX,   FP32, 1'b0, 32'h7f800001, 32'hbf800000, 32'hbf800000, 1'b1},
  '{MIN,   FP32, 1'b0, 32'h7fc00001, 32'hff800005, 32'h7fc00000, 1'b1},
  '{MAX,   FP32, 1'b0, 32'hbf800000, 32'hc0000000, 32'hbf800000, 1'b0},
  '{MIN,   FP32, 1'b0, 32'h7f800000, 32'h3f800000, 32'h3f800000, 1'b0},
  // Unboxed scalar FP16 operands count as the canonical NaN
  '{SGNJ,  FP16, 1'b0, 32'hffff3c00, 32'hffffc000, 32'hffffbc00, 1'b0},
  '{SGNJN, FP16, 1'b0, 32'hffff3c00, 32'hffff4000, 32'hffffbc00, 1'b0},
  '{SGNJX, FP16, 1'b0, 32'hffffbc00, 32'hffffc000, 32'hffff3c00, 1'b0},
  '{SGNJ,  FP16, 1'b0, 32'h00003c00, 32'hffffc000, 32'hfffffe00, 1'b0},
  '{MIN,   FP16, 1'b0, 32'h12343c00, 32'hffff4000, 32'hffff4000, 1'b0},
  '{MIN,   FP16, 1'b0, 32'h00003c00, 32'h00004000, 32'hffff7e00, 1'b0},
  '{MAX,   FP16, 1'b0, 32'hffff7c01, 32'hffff3c00, 32'hffff3c00, 1'b1},
  '{MIN,   FP16, 1'b0, 32'hffff0000, 32'hffff8000, 32'hffff8000, 1'b0},
  '{MAX,   FP16, 1'b0, 32'hffffc000, 32'hffffbc00, 32'hffffbc00, 1'b0},
  // Upper half holds signaling NaN patterns that must not reach NV
  '{MAX,   FP16, 1'b0, 32'h7c013c00, 32'h7d004000, 32'hffff7e00, 1'b0},
  // Vectorial FP16 with both halves computed independently
  '{SGNJ,  FP16, 1'b1, 32'h3c00bc00, 32'hc0004000, 32'hbc003c00, 1'b0},
  '{MIN,   FP16, 1'b1, 32'h3c00c000, 32'h40003c00, 32'h3c00c000, 1'b0},
  '{MAX,   FP16, 1'b1, 32'h7c013c00, 32'h40004000, 32'h40004000, 1'b1},
  '{MIN,   FP16, 1'b1, 32'h3c007d00, 32'hbc003c00, 32'hbc003c00, 1'b1},
  '{MAX,   FP16, 1'b1, 32'h00007e00, 32'h00007c01, 32'h00007e00, 1'b1},
  '{SGNJX, FP16, 1'b1, 32'hc0004000, 32'h80000000, 32'h40004000, 1'b0},
  // FP32 ignores the vector flag, so an FP16 signaling NaN pattern up top stays out of NV
  '{MIN,   FP32, 1'b1, 32'h7c010000, 32'h3f800000, 32'h3f800000, 1'b0}
};

`endif

//--- test/tb_fp_slice.sv
/*
 * Testbench for the packed-SIMD sign injection and min/max slice
 * Walks the stimulus table with and without back-pressure, checks
 * latency, ordering, tags and flush against a scoreboard queue
 */
`timescale 1ns/1ns

module tb_fp_slice;
  import slice_pkg::*;
  import fp_format_pkg::*;

  `include "tb_vectors.svh"

  localparam int CLK_PERIOD   = 40;
  localparam int SAMPLE_DELAY = CLK_PERIOD / 4;
  localparam int TIMEOUT_CYCLES = NUM_VECTORS * (PIPE_DEPTH + 8) + 50;

  typedef struct packed {
    slice_rsp_t rsp;
    int         cycle;
    logic       boxed;
  } expect_t;

  logic       clk_i;
  logic       rst_n_i;
  logic       flush_i;
  slice_req_t req_i;
  logic       in_valid_i;
  logic       in_ready_o;
  slice_rsp_t rsp_o;
  logic       out_valid_o;
  logic       out_ready_i;
  logic       busy_o;

  expect_t     expected_q [$];
  logic [31:0] lfsr_state = 32'hb78102bb;
  int          cycle_count = 0;
  int          value_errors = 0;
  int          protocol_errors = 0;
  logic        backpressure = 1'b0;
  logic        stall = 1'b0;
  logic        check_latency = 1'b0;

  fp_slice dut_i (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .flush_i     ( flush_i     ),
    .req_i       ( req_i       ),
    .in_valid_i  ( in_valid_i  ),
    .in_ready_o  ( in_ready_o  ),
    .rsp_o       ( rsp_o       ),
    .out_valid_o ( out_valid_o ),
    .out_ready_i ( out_ready_i ),
    .busy_o      ( busy_o      )
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  always @(posedge clk_i) cycle_count <= cycle_count + 1;

  // --------------------------------------------------------------------------
  // Random numbers
  // --------------------------------------------------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic lsb;
    lsb = s[0];
    s   = s >> 1;
    if (lsb) s = s ^ 32'h80200003;
    return s;
  endfunction

  // One LFSR step per bit handed out
  function automatic logic [31:0] draw_bits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v          = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  // --------------------------------------------------------------------------
  // Driver
  // --------------------------------------------------------------------------
  task automatic tick();
    @(negedge clk_i);
    if (stall) out_ready_i = 1'b0;
    else if (backpressure) out_ready_i = (draw_bits(1) != 0);
    else out_ready_i = 1'b1;
  endtask

  task automatic send_vector(input int idx);
    vector_t v;
    expect_t e;
    logic    accepted;
    tick();
    v = VECTORS[idx];
    req_i.operand_a = v.a;
    req_i.operand_b = v.b;
    req_i.op        = v.op;
    req_i.fmt       = v.fmt;
    req_i.vectorial = v.vectorial;
    req_i.tag       = tag_t'(draw_bits(4));
    in_valid_i      = 1'b1;
    accepted        = 1'b0;
    // Hold the request until the slice takes it
    while (!accepted) begin
      #SAMPLE_DELAY;
      accepted = in_ready_o;
      if (!accepted) tick();
    end
    e.rsp   = '{result: v.result, nv: v.nv, tag: req_i.tag};
    e.cycle = cycle_count;
    e.boxed = (v.fmt == FP16) && !v.vectorial;
    expected_q.push_back(e);
  endtask

  task automatic drain();
    tick();
    in_valid_i = 1'b0;
    while (expected_q.size() != 0) tick();
  endtask

  // --------------------------------------------------------------------------
  // Monitor, samples a quarter period before the rising edge
  // --------------------------------------------------------------------------
  task automatic check_response();
    expect_t e;
    assert (expected_q.size() != 0) else begin
      protocol_errors++;
      $display("Response with tag %0h arrived while no request was outstanding", rsp_o.tag);
    end
    if (expected_q.size() != 0) begin
      e = expected_q.pop_front();
      assert (rsp_o.tag == e.rsp.tag) else begin
        value_errors++;
        $display("FAIL %0t: tag %0h, expected %0h", $time, rsp_o.tag, e.rsp.tag);
      end
      assert (rsp_o.result == e.rsp.result) else begin
        value_errors++;
        $display("FAIL %0t: result %08h, expected %08h", $time, rsp_o.result, e.rsp.result);
      end
      assert (rsp_o.nv == e.rsp.nv) else begin
        value_errors++;
        $display("FAIL %0t: nv %0b, expected %0b", $time, rsp_o.nv, e.rsp.nv);
      end
      assert (!e.boxed || rsp_o.result[31:16] == 16'hffff) else begin
        value_errors++;
        $display("FAIL %0t: scalar FP16 result %08h not NaN-boxed", $time, rsp_o.result);
      end
      if (check_latency) begin
        assert (cycle_count - e.cycle == int'(PIPE_DEPTH)) else begin
          protocol_errors++;
          $display("Response came %0d edges after acceptance instead of %0d",
                   cycle_count - e.cycle, PIPE_DEPTH);
        end
      end
    end
  endtask

  always begin
    @(negedge clk_i);
    #SAMPLE_DELAY;
    if (rst_n_i && out_valid_o && out_ready_i) check_response();
  end

  // --------------------------------------------------------------------------
  // Watchdog
  // --------------------------------------------------------------------------
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk_i);
    $display("Timeout: the run did not finish within %0d clock periods", TIMEOUT_CYCLES);
    $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
    $display("Regression failed");
    $finish;
  end

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial begin
    rst_n_i     = 1'b0;
    flush_i     = 1'b0;
    req_i       = '0;
    in_valid_i  = 1'b0;
    out_ready_i = 1'b1;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    #SAMPLE_DELAY;
    assert (!out_valid_o && !busy_o && in_ready_o) else begin
      protocol_errors++;
      $display("Slice is not idle and ready after reset");
    end

    // Full throughput, fixed latency
    check_latency = 1'b1;
    for (int i = 0; i < NUM_VECTORS; i++) send_vector(i);
    drain();
    check_latency = 1'b0;

    // Random back-pressure on the output
    backpressure = 1'b1;
    for (int i = 0; i < NUM_VECTORS; i++) send_vector(i);
    drain();
    backpressure = 1'b0;

    // Fill both stages behind a stalled output, then flush
    stall = 1'b1;
    send_vector(0);
    send_vector(1);
    tick();
    in_valid_i = 1'b0;
    flush_i    = 1'b1;
    expected_q.delete();
    #SAMPLE_DELAY;
    assert (busy_o && out_valid_o) else begin
      protocol_errors++;
      $display("Pipeline was not full before the flush");
    end
    stall = 1'b0;
    tick();
    flush_i = 1'b0;
    #SAMPLE_DELAY;
    assert (!busy_o && !out_valid_o) else begin
      protocol_errors++;
      $display("Pipeline still busy one cycle after the flush");
    end
    repeat (4) tick();
    send_vector(5);
    drain();

    $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
    if (value_errors + protocol_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- logic/fp_slice.sv
/*
 * Packed-SIMD sign injection and min/max slice
 * Decode, two computing lanes, a register pipeline and result assembly
 * behind valid/ready handshakes on both sides
 */
`timescale 1ns/1ns

module fp_slice (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  flush_i,
  input  slice_pkg::slice_req_t req_i,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  output slice_pkg::slice_rsp_t rsp_o,
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output logic                  busy_o
);
  import slice_pkg::*;

  lane_op_vec_t  lane_ops;
  lane_res_vec_t lane_res;
  slice_aux_t    aux;
  pipe_item_t    pipe_in;
  pipe_item_t    pipe_out;

  slice_decode i_decode (
    .req_i      ( req_i    ),
    .lane_ops_o ( lane_ops ),
    .aux_o      ( aux      )
  );

  // Lane 0 handles both formats, lane 1 only the upper FP16 half
  slice_lane #(
    .HasFp32 ( 1'b1 )
  ) i_lane_0 (
    .op_i  ( lane_ops[0] ),
    .res_o ( lane_res[0] )
  );

  slice_lane #(
    .HasFp32 ( 1'b0 )
  ) i_lane_1 (
    .op_i  ( lane_ops[1] ),
    .res_o ( lane_res[1] )
  );

  assign pipe_in = '{lanes: lane_res, aux: aux};

  slice_pipe #(
    .Depth ( PIPE_DEPTH )
  ) i_pipe (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .flush_i     ( flush_i     ),
    .in_item_i   ( pipe_in     ),
    .in_valid_i  ( in_valid_i  ),
    .in_ready_o  ( in_ready_o  ),
    .out_item_o  ( pipe_out    ),
    .out_valid_o ( out_valid_o ),
    .out_ready_i ( out_ready_i ),
    .busy_o      ( busy_o      )
  );

  slice_result i_result (
    .item_i ( pipe_out ),
    .rsp_o  ( rsp_o    )
  );

endmodule

//--- logic/slice_result.sv
/*
 * Slice result assembly
 * Packs the lane values into the 32-bit result, NaN-boxes scalar FP16
 * results and merges the lane NV flags
 */
`timescale 1ns/1ns

module slice_result (
  input  slice_pkg::pipe_item_t item_i,
  output slice_pkg::slice_rsp_t rsp_o
);
  import slice_pkg::*;
  import fp_format_pkg::*;

  logic [SLICE_WIDTH-1:0] packed_fp16;
  logic                   nv;

  // ----------------------------------------------------------------------
  // Narrow packing
  // ----------------------------------------------------------------------
  always_comb begin
    for (int k = 0; k < NUM_LANES; k++) begin
      if ((k == 0) || item_i.aux.vectorial) begin
        packed_fp16[k*FP16_WIDTH +: FP16_WIDTH] = item_i.lanes[k].value[FP16_WIDTH-1:0];
      end else begin
        // Unused upper lanes are NaN-boxed
        packed_fp16[k*FP16_WIDTH +: FP16_WIDTH] = '1;
      end
    end
  end

  // Status of idle lanes is dropped before the OR
  always_comb begin
    nv = 1'b0;
    for (int k = 0; k < NUM_LANES; k++) begin
      if ((k == 0) || item_i.aux.vectorial) begin
        nv |= item_i.lanes[k].nv;
      end
    end
  end

  assign rsp_o.result = (item_i.aux.fmt == FP32) ? item_i.lanes[0].value : packed_fp16;
  assign rsp_o.nv     = nv;
  assign rsp_o.tag    = item_i.aux.tag;

endmodule

//--- logic/slice_pipe.sv
/*
 * Slice register pipeline
 * Valid/ready stages with flush and busy that carry the lane results
 * and the auxiliary bits towards result assembly
 */
`timescale 1ns/1ns

module slice_pipe #(
  parameter int unsigned Depth = slice_pkg::PIPE_DEPTH
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  flush_i,
  input  slice_pkg::pipe_item_t in_item_i,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  output slice_pkg::pipe_item_t out_item_o,
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output logic                  busy_o
);
  import slice_pkg::*;

  // Index i holds the item after i register stages
  pipe_item_t item_q  [Depth+1];
  logic       valid_q [Depth+1];
  logic       ready   [Depth+1];

  assign item_q[0]  = in_item_i;
  assign valid_q[0] = in_valid_i;

  for (genvar i = 0; i < Depth; i++) begin : gen_stage
    // Move on when the next stage takes its item or holds a bubble
    assign ready[i] = ready[i+1] | ~valid_q[i+1];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        valid_q[i+1] <= 1'b0;
      end else if (flush_i) begin
        valid_q[i+1] <= 1'b0;
      end else if (ready[i]) begin
        valid_q[i+1] <= valid_q[i];
      end
    end

    // Payload only moves with a valid item
    always_ff @(posedge clk_i) begin
      if (ready[i] && valid_q[i]) begin
        item_q[i+1] <= item_q[i];
      end
    end
  end

  // Ready runs backwards from the consumer
  assign ready[Depth] = out_ready_i;
  assign in_ready_o   = ready[0];
  assign out_item_o   = item_q[Depth];
  assign out_valid_o  = valid_q[Depth];

  always_comb begin
    busy_o = 1'b0;
    for (int i = 1; i <= Depth; i++) begin
      busy_o |= valid_q[i];
    end
  end

  // A stalled output holds still until the consumer takes it
  a_stall_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (out_valid_o && !out_ready_i && !flush_i) |=> (out_valid_o && $stable(out_item_o)))
    else $error("slice_pipe: output changed while stalled");

endmodule

//--- logic/slice_lane.sv
/*
 * Sign injection and min/max lane
 * Computes one lane result for every format enabled in the lane and
 * selects the one that matches the requested format
 */
`timescale 1ns/1ns

module slice_lane #(
  parameter bit HasFp32 = 1'b1
) (
  input  slice_pkg::lane_op_t  op_i,
  output slice_pkg::lane_res_t res_o
);
  import slice_pkg::*;
  import fp_format_pkg::*;

  localparam int unsigned NumFmts = 2 ** $bits(fp_fmt_e);

  // One candidate per format, indexed by the format encoding
  lane_res_t [NumFmts-1:0] fmt_res;

  for (genvar f = 0; f < NumFmts; f++) begin : gen_fmt
    if ((f == int'(FP32)) && !HasFp32) begin : gen_fmt_off
      assign fmt_res[f] = '0;
    end else begin : gen_fmt_on
      localparam bit          IsWide = (f == int'(FP32));
      localparam int unsigned W      = IsWide ? FP32_WIDTH : FP16_WIDTH;
      localparam int unsigned EB     = IsWide ? FP32_EXP_BITS : FP16_EXP_BITS;
      localparam int unsigned MB     = IsWide ? FP32_MAN_BITS : FP16_MAN_BITS;
      localparam logic [W-1:0] QNan  = IsWide ? W'(FP32_QNAN) : W'(FP16_QNAN);

      logic [W-1:0] a;
      logic [W-1:0] b;
      logic [W-1:0] r;
      logic         a_nan, b_nan;
      logic         a_snan, b_snan;
      logic         a_lt_b;
      logic         nv;

      assign a = op_i.a[W-1:0];
      assign b = op_i.b[W-1:0];

      // NaN class from the exponent and the top mantissa bit
      assign a_nan  = (&a[W-2 -: EB]) && (|a[MB-1:0]);
      assign b_nan  = (&b[W-2 -: EB]) && (|b[MB-1:0]);
      assign a_snan = a_nan && !a[MB-1];
      assign b_snan = b_nan && !b[MB-1];

      // Sign-magnitude ordering, -0 below +0 falls out of the sign test
      always_comb begin
        if (a[W-1] != b[W-1]) begin
          a_lt_b = a[W-1];
        end else if (a[W-1]) begin
          a_lt_b = a[W-2:0] > b[W-2:0];
        end else begin
          a_lt_b = a[W-2:0] < b[W-2:0];
        end
      end

      always_comb begin
        r  = a;
        nv = 1'b0;
        case (op_i.op)
          SGNJ:  r = {b[W-1], a[W-2:0]};
          SGNJN: r = {~b[W-1], a[W-2:0]};
          SGNJX: r = {a[W-1] ^ b[W-1], a[W-2:0]};
          MIN, MAX: begin
            nv = a_snan | b_snan;
            if (a_nan && b_nan) begin
              r = QNan;
            end else if (a_nan) begin
              r = b;
            end else if (b_nan) begin
              r = a;
            end else begin
              r = ((op_i.op == MIN) == a_lt_b) ? a : b;
            end
          end
          default: r = a;
        endcase
      end

      // Narrow results sit zero-extended in the low bits
      assign fmt_res[f].value = SLICE_WIDTH'(r);
      assign fmt_res[f].nv    = nv;
    end
  end

  assign res_o = fmt_res[op_i.fmt];

endmodule

//--- logic/slice_decode.sv
/*
 * Slice request decoder
 * Splits the operands into lane operations and replaces scalar FP16
 * operands that are not NaN-boxed by the canonical NaN
 */
`timescale 1ns/1ns

module slice_decode (
  input  slice_pkg::slice_req_t   req_i,
  output slice_pkg::lane_op_vec_t lane_ops_o,
  output slice_pkg::slice_aux_t   aux_o
);
  import slice_pkg::*;
  import fp_format_pkg::*;

  logic scalar_fp16;
  logic a_boxed;
  logic b_boxed;

  // ----------------------------------------------------------------------
  // NaN-box check
  // ----------------------------------------------------------------------
  assign scalar_fp16 = (req_i.fmt == FP16) && !req_i.vectorial;

  // A narrow value held in a wide register needs all ones above it
  assign a_boxed = &req_i.operand_a[SLICE_WIDTH-1:FP16_WIDTH];
  assign b_boxed = &req_i.operand_b[SLICE_WIDTH-1:FP16_WIDTH];

  // ----------------------------------------------------------------------
  // Lane slicing
  // ----------------------------------------------------------------------
  always_comb begin
    for (int k = 0; k < NUM_LANES; k++) begin
      lane_ops_o[k].op  = req_i.op;
      // Only lane 0 ever sees the wide format
      lane_ops_o[k].fmt = (k == 0) ? req_i.fmt : FP16;
      lane_ops_o[k].a   = req_i.operand_a >> (k * FP16_WIDTH);
      lane_ops_o[k].b   = req_i.operand_b >> (k * FP16_WIDTH);
    end

    // Unboxed scalar operands behave like a quiet NaN
    if (scalar_fp16 && !a_boxed) begin
      lane_ops_o[0].a[FP16_WIDTH-1:0] = FP16_QNAN;
    end
    if (scalar_fp16 && !b_boxed) begin
      lane_ops_o[0].b[FP16_WIDTH-1:0] = FP16_QNAN;
    end

    // Format drives lane steering here and result packing after the pipe
    assert (!$isunknown(req_i.fmt))
      else $error("slice_decode: unknown format %0b", req_i.fmt);
  end

  // ----------------------------------------------------------------------
  // Auxiliary bits
  // ----------------------------------------------------------------------
  assign aux_o.fmt = req_i.fmt;
  // A wide request has a single lane, so the vector bit means nothing there
  assign aux_o.vectorial = req_i.vectorial && (req_i.fmt == FP16);
  assign aux_o.tag       = req_i.tag;

endmodule

//--- logic/slice_pkg.sv
/*
 * Slice operation package
 * Operation encoding, tag type, pipeline depth and the structs that
 * carry requests, lane operations, lane results and responses
 */
package slice_pkg;

  localparam int unsigned SLICE_WIDTH = 32;

  // Number of register stages between lanes and result assembly
  localparam int unsigned PIPE_DEPTH = 2;

  // ----------------------------------------------------------------------
  // Operations and tag
  // ----------------------------------------------------------------------
  typedef enum logic [2:0] {
    SGNJ,
    SGNJN,
    SGNJX,
    MIN,
    MAX
  } slice_op_e;

  typedef logic [3:0] tag_t;

  // ----------------------------------------------------------------------
  // Request and response
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic [SLICE_WIDTH-1:0] operand_a;
    logic [SLICE_WIDTH-1:0] operand_b;
    slice_op_e              op;
    fp_format_pkg::fp_fmt_e fmt;
    logic                   vectorial;
    tag_t                   tag;
  } slice_req_t;

  typedef struct packed {
    logic [SLICE_WIDTH-1:0] result;
    logic                   nv;
    tag_t                   tag;
  } slice_rsp_t;

  // ----------------------------------------------------------------------
  // Lane level
  // ----------------------------------------------------------------------
  // Upper lanes only look at the low FP16 bits of a and b
  typedef struct packed {
    slice_op_e              op;
    fp_format_pkg::fp_fmt_e fmt;
    logic [SLICE_WIDTH-1:0] a;
    logic [SLICE_WIDTH-1:0] b;
  } lane_op_t;

  typedef struct packed {
    logic [SLICE_WIDTH-1:0] value;
    logic                   nv;
  } lane_res_t;

  typedef lane_op_t  [fp_format_pkg::NUM_LANES-1:0] lane_op_vec_t;
  typedef lane_res_t [fp_format_pkg::NUM_LANES-1:0] lane_res_vec_t;

  // Side information that rides along with the lane results
  typedef struct packed {
    fp_format_pkg::fp_fmt_e fmt;
    logic                   vectorial;
    tag_t                   tag;
  } slice_aux_t;

  typedef struct packed {
    lane_res_vec_t lanes;
    slice_aux_t    aux;
  } pipe_item_t;

endpackage

//--- logic/fp_format_pkg.sv
/*
 * Floating-point format definitions
 * Encodings, field widths and canonical NaNs of the FP32 and FP16
 * formats handled by the slice, and the lane count they imply
 */
package fp_format_pkg;

  // ----------------------------------------------------------------------
  // Format selection
  // ----------------------------------------------------------------------
  typedef enum logic {
    FP32 = 1'b0,
    FP16 = 1'b1
  } fp_fmt_e;

  // ----------------------------------------------------------------------
  // Field widths
  // ----------------------------------------------------------------------
  // Single precision
  localparam int unsigned FP32_WIDTH    = 32;
  localparam int unsigned FP32_EXP_BITS = 8;
  localparam int unsigned FP32_MAN_BITS = 23;

  // Half precision
  localparam int unsigned FP16_WIDTH    = 16;
  localparam int unsigned FP16_EXP_BITS = 5;
  localparam int unsigned FP16_MAN_BITS = 10;

  // ----------------------------------------------------------------------
  // Canonical quiet NaNs
  // ----------------------------------------------------------------------
  // Positive sign, exponent all ones, only the quiet bit set
  localparam logic [FP32_WIDTH-1:0] FP32_QNAN = 32'h7fc00000;
  localparam logic [FP16_WIDTH-1:0] FP16_QNAN = 16'h7e00;

  // Narrowest format decides how many lanes fit side by side
  localparam int unsigned NUM_LANES = FP32_WIDTH / FP16_WIDTH;

endpackage
